// File: Bender.yml
package:
  name: lsu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_ctrl.sv
      - hdl/lsu_addr_split.sv
      - hdl/lsu_rdata_align.sv
      - hdl/lsu_txn_counter.sv
      - hdl/lsu_bus_monitor.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/lsu_mem_model.sv
      - tests/lsu_tb.sv

// File: hdl/lsu_addr_split.sv
`include "lsu_consts.svh"

module lsu_addr_split (
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              second_half_i,
  output lsu_pkg::obi_req_t half_req_o,
  output logic              split_o
);

  logic [1:0]                 offset;
  logic [`LSU_DATA_W/8-1:0]   size_mask;
  logic [`LSU_DATA_W/4-1:0]   be_wide;
  logic [2*`LSU_DATA_W-1:0]   wdata_wide;
  logic [`LSU_DATA_W-3:0]     word_idx;

  always_comb begin
    offset   = req_i.addr[1:0];
    word_idx = req_i.addr[`LSU_DATA_W-1:2];

    // Lanes touched by an aligned access, and whether the access runs past lane 3
    case (req_i.size)
      lsu_pkg::LSU_SIZE_BYTE: begin
        size_mask = 4'b0001;
        split_o   = 1'b0;
      end
      lsu_pkg::LSU_SIZE_HALF: begin
        size_mask = 4'b0011;
        split_o   = (offset == 2'd3);
      end
      lsu_pkg::LSU_SIZE_WORD: begin
        size_mask = 4'b1111;
        split_o   = (offset != 2'd0);
      end
      default: begin
        size_mask = 4'b0000;
        split_o   = 1'b0;
      end
    endcase

    // Over two words, the low word holds the first half and the high word the second
    be_wide    = {4'b0000, size_mask} << offset;
    wdata_wide = {{`LSU_DATA_W{1'b0}}, req_i.wdata} << {offset, 3'b000};

    // The controller owns req
    half_req_o.req = 1'b0;
    half_req_o.we  = req_i.we;
    if (second_half_i) begin
      half_req_o.addr  = {word_idx + 1'b1, 2'b00};
      half_req_o.be    = be_wide[`LSU_DATA_W/4-1:`LSU_DATA_W/8];
      half_req_o.wdata = wdata_wide[2*`LSU_DATA_W-1:`LSU_DATA_W];
    end else begin
      half_req_o.addr  = {word_idx, 2'b00};
      half_req_o.be    = be_wide[`LSU_DATA_W/8-1:0];
      half_req_o.wdata = wdata_wide[`LSU_DATA_W-1:0];
    end
  end

endmodule

// File: hdl/lsu_bus_monitor.sv
`include "lsu_consts.svh"

module lsu_bus_monitor (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [2:0]        cnt_i,
  input  logic              rvalid_i,
  input  logic              req_valid_i,
  input  logic              busy_i,
  output lsu_pkg::lsu_err_t err_o
);

  lsu_pkg::lsu_err_t err_q;

  ////////////////////
  // Sticky flags
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= '0;
    end else begin
      // Every read-valid must answer an earlier grant
      if (rvalid_i && (cnt_i == 3'd0)) err_q.spurious_rvalid <= 1'b1;
      // The controller never issues past the bus depth
      if (cnt_i > `LSU_MAX_OUTSTANDING) err_q.count_overflow <= 1'b1;
      // The pipeline has no stall, so a strobe during busy is lost
      if (req_valid_i && busy_i) err_q.req_while_busy <= 1'b1;
    end
  end

  assign err_o = err_q;

endmodule

// File: hdl/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

////////////////////
// Bus geometry
////////////////////

// Width of the data bus, of the address and of the pipeline data path
// Byte enables are derived from this as one bit per byte lane
`define LSU_DATA_W 32

////////////////////
// Bus depth
////////////////////

// Most bus transactions that may be granted but not yet answered
// A split access is the only way to reach this depth
`define LSU_MAX_OUTSTANDING 2

`endif

// File: hdl/lsu_ctrl.sv
module lsu_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  lsu_pkg::obi_req_t half_req_i,
  input  logic              split_i,
  input  logic              obi_gnt_i,
  input  logic              last_rvalid_i,
  output logic              busy_o,
  output logic              second_half_o,
  output lsu_pkg::obi_req_t obi_req_o,
  output logic              rsp_valid_o,
  output lsu_pkg::lsu_req_t req_q_o
);

  lsu_pkg::lsu_state_e state_q;
  lsu_pkg::lsu_state_e state_d;
  lsu_pkg::lsu_req_t   req_q;
  logic                rsp_valid_q;
  logic                accept;

  // A strobe is only taken while idle, anything else is dropped
  assign accept = req_valid_i && (state_q == lsu_pkg::LSU_ST_IDLE);

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::LSU_ST_IDLE: begin
        if (accept) state_d = lsu_pkg::LSU_ST_FIRST;
      end
      lsu_pkg::LSU_ST_FIRST: begin
        // The second half goes out right away, without waiting for rvalid
        if (obi_gnt_i) state_d = split_i ? lsu_pkg::LSU_ST_SECOND : lsu_pkg::LSU_ST_WAIT;
      end
      lsu_pkg::LSU_ST_SECOND: begin
        if (obi_gnt_i) state_d = lsu_pkg::LSU_ST_WAIT;
      end
      lsu_pkg::LSU_ST_WAIT: begin
        if (last_rvalid_i) state_d = lsu_pkg::LSU_ST_IDLE;
      end
      default: state_d = lsu_pkg::LSU_ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= lsu_pkg::LSU_ST_IDLE;
      req_q       <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // Completion lands one cycle after the last read-valid
      rsp_valid_q <= (state_q == lsu_pkg::LSU_ST_WAIT) && last_rvalid_i;
      if (accept) req_q <= req_i;
    end
  end

  // Payload stays fixed while req waits for gnt, it only depends on req_q and the state
  always_comb begin
    obi_req_o     = half_req_i;
    obi_req_o.req = (state_q == lsu_pkg::LSU_ST_FIRST) || (state_q == lsu_pkg::LSU_ST_SECOND);
  end

  assign busy_o        = (state_q != lsu_pkg::LSU_ST_IDLE);
  assign second_half_o = (state_q == lsu_pkg::LSU_ST_SECOND);
  assign rsp_valid_o   = rsp_valid_q;
  assign req_q_o       = req_q;

endmodule

// File: hdl/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

  // Access size as encoded by the pipeline
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

  // Controller states, one per bus phase of a request
  typedef enum logic [1:0] {
    LSU_ST_IDLE,
    LSU_ST_FIRST,
    LSU_ST_SECOND,
    LSU_ST_WAIT
  } lsu_state_e;

  ////////////////////
  // Pipeline side
  ////////////////////

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    lsu_size_e              size;
    logic                   sext;
    logic [`LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   we;
  } lsu_rsp_t;

  ////////////////////
  // Bus side
  ////////////////////

  typedef struct packed {
    logic                     req;
    logic [`LSU_DATA_W-1:0]   addr;
    logic                     we;
    logic [`LSU_DATA_W/8-1:0] be;
    logic [`LSU_DATA_W-1:0]   wdata;
  } obi_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [`LSU_DATA_W-1:0] rdata;
  } obi_rsp_t;

  // Sticky protocol error flags, cleared only by reset
  typedef struct packed {
    logic spurious_rvalid;
    logic count_overflow;
    logic req_while_busy;
  } lsu_err_t;

endpackage

// File: hdl/lsu_rdata_align.sv
`include "lsu_consts.svh"

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_pkg::lsu_req_t      req_i,
  input  logic                   split_i,
  input  logic                   obi_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] obi_rdata_i,
  output logic                   last_rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  logic                     first_done_q;
  logic [`LSU_DATA_W-1:0]   first_word_q;
  logic [2*`LSU_DATA_W-1:0] merged;
  logic [2*`LSU_DATA_W-1:0] shifted;
  logic [`LSU_DATA_W-1:0]   aligned;
  logic [`LSU_DATA_W-1:0]   rdata_q;

  // Read-valids come in grant order, so the first one of a split is the low word
  assign last_rvalid_o = obi_rvalid_i && (!split_i || first_done_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_done_q <= 1'b0;
    end else if (obi_rvalid_i) begin
      first_done_q <= !last_rvalid_o;
    end
  end

  always_ff @(posedge clk) begin
    if (obi_rvalid_i && !last_rvalid_o) first_word_q <= obi_rdata_i;
    // Result is held until the next request finishes
    if (last_rvalid_o) rdata_q <= aligned;
  end

  ////////////////////
  // Shift and extend
  ////////////////////

  always_comb begin
    merged  = split_i ? {obi_rdata_i, first_word_q} : {{`LSU_DATA_W{1'b0}}, obi_rdata_i};
    shifted = merged >> {req_i.addr[1:0], 3'b000};
    case (req_i.size)
      lsu_pkg::LSU_SIZE_BYTE: begin
        aligned = {{(`LSU_DATA_W-8){req_i.sext & shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::LSU_SIZE_HALF: begin
        aligned = {{(`LSU_DATA_W-16){req_i.sext & shifted[15]}}, shifted[15:0]};
      end
      default: aligned = shifted[`LSU_DATA_W-1:0];
    endcase
  end

  assign rdata_o = rdata_q;

endmodule

// File: hdl/lsu_top.sv
`include "lsu_consts.svh"

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              busy_o,
  output logic              rsp_valid_o,
  output lsu_pkg::lsu_rsp_t rsp_o,
  output lsu_pkg::obi_req_t obi_req_o,
  input  lsu_pkg::obi_rsp_t obi_rsp_i,
  output lsu_pkg::lsu_err_t err_o
);

  lsu_pkg::lsu_req_t      req_q;
  lsu_pkg::obi_req_t      half_req;
  logic                   split;
  logic                   second_half;
  logic                   last_rvalid;
  logic                   bus_gnt;
  logic [2:0]             txn_cnt;
  logic [`LSU_DATA_W-1:0] rdata;

  // A grant only counts while req is up
  assign bus_gnt = obi_req_o.req & obi_rsp_i.gnt;

  lsu_ctrl ctrl_i (
    .clk, .rst_n, .req_valid_i, .req_i, .half_req_i(half_req), .split_i(split),
    .obi_gnt_i(bus_gnt), .last_rvalid_i(last_rvalid), .busy_o,
    .second_half_o(second_half), .obi_req_o, .rsp_valid_o, .req_q_o(req_q)
  );

  lsu_addr_split split_i (
    .req_i(req_q), .second_half_i(second_half), .half_req_o(half_req), .split_o(split)
  );

  lsu_rdata_align align_i (
    .clk, .rst_n, .req_i(req_q), .split_i(split), .obi_rvalid_i(obi_rsp_i.rvalid),
    .obi_rdata_i(obi_rsp_i.rdata), .last_rvalid_o(last_rvalid), .rdata_o(rdata)
  );

  lsu_txn_counter counter_i (
    .clk, .rst_n, .gnt_i(bus_gnt), .rvalid_i(obi_rsp_i.rvalid), .cnt_o(txn_cnt)
  );

  lsu_bus_monitor monitor_i (
    .clk, .rst_n, .cnt_i(txn_cnt), .rvalid_i(obi_rsp_i.rvalid), .req_valid_i,
    .busy_i(busy_o), .err_o
  );

  // Stores complete as well, the write flag tells them apart
  assign rsp_o.rdata = rdata;
  assign rsp_o.we    = req_q.we;

endmodule

// File: hdl/lsu_txn_counter.sv
module lsu_txn_counter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       gnt_i,
  input  logic       rvalid_i,
  output logic [2:0] cnt_o
);

  logic [2:0] cnt_q;

  // Grant and read-valid in the same cycle leave the count unchanged
  // Both ends saturate, so a stray read-valid cannot wrap the count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 3'd0;
    end else begin
      case ({gnt_i, rvalid_i})
        2'b10: begin
          if (cnt_q != 3'b111) cnt_q <= cnt_q + 3'd1;
        end
        2'b01: begin
          if (cnt_q != 3'b000) cnt_q <= cnt_q - 3'd1;
        end
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign cnt_o = cnt_q;

endmodule

// File: tb.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_ctrl.sv
hdl/lsu_addr_split.sv
hdl/lsu_rdata_align.sv
hdl/lsu_txn_counter.sv
hdl/lsu_bus_monitor.sv
hdl/lsu_top.sv
tests/lsu_mem_model.sv
tests/lsu_tb.sv

// File: tests/lsu_mem_model.sv
`include "lsu_consts.svh"

module lsu_mem_model (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::obi_req_t obi_req_i,
  output lsu_pkg::obi_rsp_t obi_rsp_o,
  input  logic              inject_i,
  input  logic              stats_clr_i,
  output int                grants_o,
  output int                max_inflight_o
);

  logic [7:0]             mem [256];
  logic [`LSU_DATA_W-1:0] rdata_q [$];
  int                     due_q [$];
  int                     cyc;
  int                     gnt_wait;
  int                     inflight;
  integer                 seed = 32'hf701;
  logic                   rvalid;
  logic [`LSU_DATA_W-1:0] rdata;
  logic [`LSU_DATA_W-1:0] word;
  logic [7:0]             base;

  // The byte at address a holds the low byte of a * 7 + 3
  initial begin
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'(a * 7 + 3);
    end
  end

  // Grant comes once the drawn delay has run out
  always_comb begin
    obi_rsp_o.gnt    = obi_req_i.req && (gnt_wait == 0);
    obi_rsp_o.rvalid = rvalid;
    obi_rsp_o.rdata  = rdata;
  end

  ////////////////////
  // Bus slave
  ////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc            <= 0;
      gnt_wait       <= 0;
      rvalid         <= 1'b0;
      rdata          <= '0;
      grants_o       <= 0;
      max_inflight_o <= 0;
    end else begin
      cyc    <= cyc + 1;
      rvalid <= 1'b0;
      if (stats_clr_i) begin
        grants_o       <= 0;
        max_inflight_o <= 0;
      end
      if (obi_rsp_o.gnt) begin
        // Writes land and reads are taken at grant time, in grant order
        base     = obi_req_i.addr[7:0];
        inflight = rdata_q.size() + 1;
        for (int b = 0; b < `LSU_DATA_W/8; b++) begin
          if (obi_req_i.we && obi_req_i.be[b]) mem[base + b] = obi_req_i.wdata[8*b +: 8];
          word[8*b +: 8] = mem[base + b];
        end
        rdata_q.push_back(obi_req_i.we ? '0 : word);
        due_q.push_back(cyc + 1 + ($unsigned($random(seed)) % 2));
        gnt_wait <= $unsigned($random(seed)) % 4;
        grants_o <= grants_o + 1;
        if (inflight > max_inflight_o) max_inflight_o <= inflight;
      end else if (obi_req_i.req && gnt_wait != 0) begin
        gnt_wait <= gnt_wait - 1;
      end
      // A response leaves 1 to 2 cycles after its grant, and only while req is low
      // so the first half of a split is still open when the second half is granted
      if (!obi_req_i.req && rdata_q.size() != 0 && cyc >= due_q[0]) begin
        rvalid <= 1'b1;
        rdata  <= rdata_q.pop_front();
        void'(due_q.pop_front());
      end else if (inject_i && !obi_req_i.req && rdata_q.size() == 0) begin
        // Stray read-valid with nothing outstanding
        rvalid <= 1'b1;
        rdata  <= 32'h0bad_0bad;
      end
    end
  end

endmodule

// File: tests/lsu_tb.sv
`include "lsu_consts.svh"

module lsu_tb;

  localparam int NUM_TESTS   = 19;
  localparam int CYCLE_LIMIT = 40 * NUM_TESTS;

  localparam lsu_pkg::lsu_size_e SZ_B = lsu_pkg::LSU_SIZE_BYTE;
  localparam lsu_pkg::lsu_size_e SZ_H = lsu_pkg::LSU_SIZE_HALF;
  localparam lsu_pkg::lsu_size_e SZ_W = lsu_pkg::LSU_SIZE_WORD;

  // K_BUSY strobes a second time while the first request runs
  typedef enum logic [1:0] {K_LOAD, K_STORE, K_BUSY, K_INJECT} kind_e;

  typedef struct packed {
    kind_e                  kind;
    lsu_pkg::lsu_req_t      req;
    logic [`LSU_DATA_W-1:0] exp_rdata;
    logic [1:0]             exp_grants;
    logic [1:0]             exp_inflight;
    lsu_pkg::lsu_err_t      exp_err;
  } entry_t;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  lsu_pkg::lsu_req_t req;
  logic              busy;
  logic              rsp_valid;
  lsu_pkg::lsu_rsp_t rsp;
  lsu_pkg::obi_req_t obi_req;
  lsu_pkg::obi_rsp_t obi_rsp;
  lsu_pkg::lsu_err_t err;
  logic              inject;
  logic              stats_clr;
  int                grants;
  int                max_inflight;
  entry_t            tbl [NUM_TESTS];
  int                fail_cnt;
  int                cycles;

  lsu_top dut_i (
    .clk, .rst_n, .req_valid_i(req_valid), .req_i(req), .busy_o(busy),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp), .obi_req_o(obi_req), .obi_rsp_i(obi_rsp), .err_o(err)
  );

  lsu_mem_model mem_i (
    .clk, .rst_n, .obi_req_i(obi_req), .obi_rsp_o(obi_rsp), .inject_i(inject),
    .stats_clr_i(stats_clr), .grants_o(grants), .max_inflight_o(max_inflight)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic entry_t make_entry(kind_e kind, logic [31:0] addr, lsu_pkg::lsu_size_e size,
      logic sext, logic [31:0] wdata, logic [31:0] rdata, logic [1:0] n_grants,
      logic [1:0] n_inflight, lsu_pkg::lsu_err_t exp_err);
    entry_t e;
    e.kind         = kind;
    e.req.addr     = addr;
    e.req.we       = (kind == K_STORE);
    e.req.size     = size;
    e.req.sext     = sext;
    e.req.wdata    = wdata;
    e.exp_rdata    = rdata;
    e.exp_grants   = n_grants;
    e.exp_inflight = n_inflight;
    e.exp_err      = exp_err;
    return e;
  endfunction

  ////////////////////
  // Stimulus table
  ////////////////////

  // Load values follow the byte rule of the memory, patched by the stores above them
  task automatic load_table();
    tbl[0]  = make_entry(K_LOAD, 32'h10, SZ_W, 0, 32'h0, 32'h8881_7a73, 1, 1, 3'b000);
    tbl[1]  = make_entry(K_LOAD, 32'h12, SZ_B, 1, 32'h0, 32'hffff_ff81, 1, 1, 3'b000);
    tbl[2]  = make_entry(K_LOAD, 32'h12, SZ_B, 0, 32'h0, 32'h0000_0081, 1, 1, 3'b000);
    tbl[3]  = make_entry(K_LOAD, 32'h12, SZ_H, 1, 32'h0, 32'hffff_8881, 1, 1, 3'b000);
    tbl[4]  = make_entry(K_LOAD, 32'h10, SZ_H, 0, 32'h0, 32'h0000_7a73, 1, 1, 3'b000);
    tbl[5]  = make_entry(K_STORE, 32'h20, SZ_W, 0, 32'h1122_3344, 32'h0, 1, 1, 3'b000);
    tbl[6]  = make_entry(K_STORE, 32'h22, SZ_H, 0, 32'h0000_beef, 32'h0, 1, 1, 3'b000);
    tbl[7]  = make_entry(K_STORE, 32'h21, SZ_B, 0, 32'h0000_00a5, 32'h0, 1, 1, 3'b000);
    tbl[8]  = make_entry(K_LOAD, 32'h20, SZ_W, 0, 32'h0, 32'hbeef_a544, 1, 1, 3'b000);
    tbl[9]  = make_entry(K_LOAD, 32'h21, SZ_H, 1, 32'h0, 32'hffff_efa5, 1, 1, 3'b000);
    tbl[10] = make_entry(K_LOAD, 32'h23, SZ_B, 0, 32'h0, 32'h0000_00be, 1, 1, 3'b000);
    // Accesses that cross a word boundary take two bus transactions
    tbl[11] = make_entry(K_LOAD, 32'h33, SZ_W, 0, 32'h0, 32'h7d76_6f68, 2, 2, 3'b000);
    tbl[12] = make_entry(K_LOAD, 32'h37, SZ_H, 1, 32'h0, 32'hffff_8b84, 2, 2, 3'b000);
    tbl[13] = make_entry(K_STORE, 32'h41, SZ_W, 0, 32'hcafe_f00d, 32'h0, 2, 2, 3'b000);
    tbl[14] = make_entry(K_LOAD, 32'h40, SZ_W, 0, 32'h0, 32'hfef0_0dc3, 1, 1, 3'b000);
    tbl[15] = make_entry(K_LOAD, 32'h44, SZ_B, 0, 32'h0, 32'h0000_00ca, 1, 1, 3'b000);
    tbl[16] = make_entry(K_BUSY, 32'h10, SZ_W, 0, 32'h0, 32'h8881_7a73, 1, 1, 3'b001);
    tbl[17] = make_entry(K_INJECT, 32'h0, SZ_W, 0, 32'h0, 32'h0, 0, 0, 3'b101);
    tbl[18] = make_entry(K_LOAD, 32'h44, SZ_B, 1, 32'h0, 32'hffff_ffca, 1, 1, 3'b101);
  endtask

  task automatic run_entry(input int idx);
    entry_t e;
    logic   failed;
    int     completions;
    e      = tbl[idx];
    failed = 1'b0;
    @(posedge clk);
    stats_clr <= 1'b1;
    req_valid <= (e.kind != K_INJECT);
    inject    <= (e.kind == K_INJECT);
    req       <= e.req;
    @(negedge clk);
    if (busy !== 1'b0) begin
      $display("[ERROR] t=%0t busy_o expected 0 got %b", $time, busy);
      failed = 1'b1;
    end
    @(posedge clk);
    stats_clr <= 1'b0;
    inject    <= 1'b0;
    req_valid <= (e.kind == K_BUSY);
    @(negedge clk);
    // Busy must hold until the completion strobe
    while (e.kind != K_INJECT && rsp_valid !== 1'b1) begin
      if (busy !== 1'b1) begin
        $display("[ERROR] t=%0t busy_o expected 1 got %b", $time, busy);
        failed = 1'b1;
      end
      @(posedge clk);
      req_valid <= 1'b0;
      @(negedge clk);
    end
    if (e.kind != K_INJECT) begin
      if (busy !== 1'b0) begin
        $display("[ERROR] t=%0t busy_o expected 0 got %b", $time, busy);
        failed = 1'b1;
      end
      if (rsp.we !== (e.kind == K_STORE)) begin
        $display("[ERROR] t=%0t rsp_o.we expected %b got %b", $time, e.kind == K_STORE, rsp.we);
        failed = 1'b1;
      end
      if (e.kind != K_STORE && rsp.rdata !== e.exp_rdata) begin
        $display("[ERROR] t=%0t rsp_o.rdata expected %h got %h", $time, e.exp_rdata, rsp.rdata);
        failed = 1'b1;
      end
    end
    // A dropped strobe or a stray read-valid must not produce a completion
    completions = (e.kind != K_INJECT);
    repeat (6) begin
      @(negedge clk);
      if (rsp_valid === 1'b1) completions++;
    end
    if (completions != (e.kind != K_INJECT)) begin
      $display("Test %0d saw %0d completion strobes where one per request is allowed",
               idx, completions);
      failed = 1'b1;
    end
    if (grants != e.exp_grants) begin
      $display("[ERROR] t=%0t grants expected %0d got %0d", $time, e.exp_grants, grants);
      failed = 1'b1;
    end
    if (max_inflight != e.exp_inflight) begin
      $display("[ERROR] t=%0t max_inflight expected %0d got %0d",
               $time, e.exp_inflight, max_inflight);
      failed = 1'b1;
    end
    if (err !== e.exp_err) begin
      $display("[ERROR] t=%0t err_o expected %b got %b", $time, e.exp_err, err);
      failed = 1'b1;
    end
    $display("Test %0d %s addr %h: %s", idx, e.kind.name(), e.req.addr, failed ? "FAILED" : "ok");
    if (failed) fail_cnt++;
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, a request never finished", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    inject    = 1'b0;
    stats_clr = 1'b0;
    fail_cnt  = 0;
    load_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end
    $display("%0d tests, %0d passed, %0d failed", NUM_TESTS, NUM_TESTS - fail_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
